//--- all.f
logic/cnn_dim_pkg.sv
logic/cnn_ctrl_pkg.sv
logic/feature_ram.sv
logic/layer_ctrl.sv
logic/conv_engine.sv
logic/pool_engine.sv
logic/cnn_top.sv
verif/cnn_assert.sv
verif/cnn_checker.sv
verif/cnn_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cnn_tb -f all.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

./obj_dir/Vcnn_tb > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST PASSED" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

//--- verif/cnn_tb.sv
`timescale 1ns/10ps

module cnn_tb
    import cnn_dim_pkg::*;
    import cnn_ctrl_pkg::*;
();

    localparam int IMG_SIZE     = 8;
    localparam int IMG_AW       = $clog2(IMG_SIZE * IMG_SIZE);
    localparam int MAP_SIZE     = IMG_SIZE - 2;
    localparam int POOL_RESULTS = (MAP_SIZE / 2) * (MAP_SIZE / 2);
    localparam int CLK_PERIOD   = 4;
    localparam int RST_CYCLES   = 8;
    localparam int N_TESTS      = 6;
    localparam int RAND_SEED    = 27277;
    // conv reads, pool reads and load slack per run
    localparam int RUN_CYCLES   = MAP_SIZE * MAP_SIZE * 12 + POOL_RESULTS * 6 + 50;
    localparam int WATCHDOG_NS  = (RST_CYCLES + N_TESTS * RUN_CYCLES) * CLK_PERIOD;

    typedef enum int {FILL_RAMP, FILL_CONST, FILL_RAND, FILL_NEG, FILL_KEEP} fill_kind_t;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   start;
    logic                   img_wr_en;
    logic [IMG_AW-1:0]      img_wr_addr;
    pix_t                   img_wr_data;
    logic                   coef_wr_en;
    logic [COEF_ADDR_W-1:0] coef_wr_addr;
    pix_t                   coef_wr_data;
    logic                   busy;
    logic                   done;
    logic                   out_valid;
    pix_t                   out_data;
    int                     cur_results;
    int                     tests_run;
    int                     tests_failed;
    int                     errors;

    ////////////////////////////////////////////////////////////
    // stimulus table with weights and bias in Q8.8
    ////////////////////////////////////////////////////////////

    string      t_name    [N_TESTS] = '{"ramp_mixed", "sat_high", "sat_low",
                                        "neg_image", "restart_ignored", "keep_image"};
    fill_kind_t t_fill    [N_TESTS] = '{FILL_RAMP, FILL_CONST, FILL_CONST,
                                        FILL_NEG, FILL_RAND, FILL_KEEP};
    int         t_wt [N_TESTS][KER_TAPS] = '{
        '{256, -128, 64, 32, 512, -256, 0, 128, -64},
        '{32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767, 32767},
        '{-32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768, -32768},
        '{0, 0, 0, 0, 256, 0, 0, 0, 0},     // identity kernel so the map is the image interior
        '{64, 128, 64, 128, 256, 128, 64, 128, 64},
        '{-256, 0, 256, -512, 0, 512, -256, 0, 256}
    };
    int         t_bias    [N_TESTS] = '{16, 0, 0, 0, -256, 128};
    bit         t_restart [N_TESTS] = '{0, 0, 0, 0, 1, 0};
    int         t_results [N_TESTS] = '{POOL_RESULTS, POOL_RESULTS, POOL_RESULTS,
                                        POOL_RESULTS, POOL_RESULTS, POOL_RESULTS};

    cnn_top #(
        .IMG_SIZE (IMG_SIZE)
    ) DUT (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .img_wr_en    (img_wr_en),
        .img_wr_addr  (img_wr_addr),
        .img_wr_data  (img_wr_data),
        .coef_wr_en   (coef_wr_en),
        .coef_wr_addr (coef_wr_addr),
        .coef_wr_data (coef_wr_data),
        .busy         (busy),
        .done         (done),
        .out_valid    (out_valid),
        .out_data     (out_data)
    );

    cnn_checker #(
        .IMG_SIZE (IMG_SIZE)
    ) u_checker (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .busy         (busy),
        .done         (done),
        .img_wr_en    (img_wr_en),
        .img_wr_addr  (img_wr_addr),
        .img_wr_data  (img_wr_data),
        .coef_wr_en   (coef_wr_en),
        .coef_wr_addr (coef_wr_addr),
        .coef_wr_data (coef_wr_data),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .exp_results  (cur_results),
        .tests_run    (tests_run),
        .tests_failed (tests_failed),
        .errors       (errors)
    );

    bind cnn_top cnn_assert #(
        .IMG_SIZE (IMG_SIZE)
    ) u_cnn_assert (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .out_valid  (out_valid),
        .img_wr_en  (img_wr_en),
        .coef_wr_en (coef_wr_en),
        .state      (u_layer_ctrl.state)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////
    // loaders drive every input on the falling edge
    ////////////////////////////////////////////////////////////

    function automatic pix_t fill_value(fill_kind_t kind, int addr);
        case (kind)
            FILL_RAMP:  return pix_t'(addr * 24 - 512);
            FILL_CONST: return pix_t'(32512);                  // 127.0
            FILL_RAND:  return pix_t'(int'($urandom_range(4095, 0)) - 2048);
            FILL_NEG:   return pix_t'(-int'($urandom_range(12288, 1)));
            default:    return '0;
        endcase
    endfunction

    task automatic load_coefs(int idx);
        for (int k = 0; k <= COEF_BIAS_IDX; k++) begin
            @(negedge clk);
            coef_wr_en   = 1'b1;
            coef_wr_addr = COEF_ADDR_W'(k);
            if (k == COEF_BIAS_IDX) begin
                coef_wr_data = pix_t'(t_bias[idx]);
            end else begin
                coef_wr_data = pix_t'(t_wt[idx][k]);
            end
        end
        @(negedge clk);
        coef_wr_en = 1'b0;
    endtask

    task automatic load_image(int idx);
        for (int a = 0; a < IMG_SIZE * IMG_SIZE; a++) begin
            @(negedge clk);
            img_wr_en   = 1'b1;
            img_wr_addr = IMG_AW'(a);
            img_wr_data = fill_value(t_fill[idx], a);
        end
        @(negedge clk);
        img_wr_en = 1'b0;
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_done();
        do begin
            @(negedge clk);
        end while (!done);
    endtask

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: runs did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(RAND_SEED));
        rst          = 1'b1;
        start        = 1'b0;
        img_wr_en    = 1'b0;
        img_wr_addr  = '0;
        img_wr_data  = '0;
        coef_wr_en   = 1'b0;
        coef_wr_addr = '0;
        coef_wr_data = '0;
        cur_results  = POOL_RESULTS;
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < N_TESTS; i++) begin
            load_coefs(i);
            if (t_fill[i] != FILL_KEEP) begin
                load_image(i);
            end
            // checker reads these at done, so they change only between runs
            u_checker.test_name = t_name[i];
            cur_results         = t_results[i];
            pulse_start();
            if (t_restart[i]) begin
                repeat (4) @(negedge clk);
                pulse_start();      // lands while busy
            end
            wait_done();
        end

        repeat (2) @(negedge clk);
        $display("summary: %0d of %0d tests run, %0d failed, %0d errors, %0d assertion failures",
                 tests_run, N_TESTS, tests_failed, errors, DUT.u_cnn_assert.fail_count);
        if (errors == 0 && tests_failed == 0 && tests_run == N_TESTS &&
            DUT.u_cnn_assert.fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verif/cnn_checker.sv
`timescale 1ns/10ps

module cnn_checker
    import cnn_dim_pkg::*;
    import cnn_ctrl_pkg::*;
#(
    parameter  int IMG_SIZE = 8,
    localparam int IMG_AW   = $clog2(IMG_SIZE * IMG_SIZE)
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   busy,
    input  logic                   done,
    input  logic                   img_wr_en,
    input  logic [IMG_AW-1:0]      img_wr_addr,
    input  pix_t                   img_wr_data,
    input  logic                   coef_wr_en,
    input  logic [COEF_ADDR_W-1:0] coef_wr_addr,
    input  pix_t                   coef_wr_data,
    input  logic                   out_valid,
    input  pix_t                   out_data,
    input  int                     exp_results,
    output int                     tests_run,
    output int                     tests_failed,
    output int                     errors
);

    localparam int KER_DIM   = 3;
    localparam int MAP_SIZE  = IMG_SIZE - 2;
    localparam int POOL_SIZE = MAP_SIZE / 2;

    string test_name;                   // written by the testbench before each start
    pix_t  img [IMG_SIZE * IMG_SIZE];   // shadow of the image RAM
    pix_t  coef [KER_TAPS + 1];         // weights, then bias
    pix_t  expected [$];
    int    got;
    int    test_errs;
    bit    running;

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    function automatic pix_t conv_pixel(int r, int c);
        longint sum;
        longint total;
        sum = 0;
        for (int ky = 0; ky < KER_DIM; ky++) begin
            for (int kx = 0; kx < KER_DIM; kx++) begin
                sum += longint'(img[(r + ky) * IMG_SIZE + c + kx])
                     * longint'(coef[ky * KER_DIM + kx]);
            end
        end
        total = (sum >>> FRAC_W) + longint'(coef[COEF_BIAS_IDX]);    // floor, then bias
        if (total > longint'(PIX_MAX)) begin
            return PIX_MAX;
        end else if (total < longint'(PIX_MIN)) begin
            return PIX_MIN;
        end
        return pix_t'(total);
    endfunction

    function automatic void build_expected();
        pix_t cmap [MAP_SIZE * MAP_SIZE];
        pix_t best;
        pix_t v;
        expected.delete();
        for (int r = 0; r < MAP_SIZE; r++) begin
            for (int c = 0; c < MAP_SIZE; c++) begin
                cmap[r * MAP_SIZE + c] = conv_pixel(r, c);
            end
        end
        for (int pr = 0; pr < POOL_SIZE; pr++) begin
            for (int pc = 0; pc < POOL_SIZE; pc++) begin
                best = cmap[2 * pr * MAP_SIZE + 2 * pc];
                for (int q = 1; q < 4; q++) begin
                    v = cmap[(2 * pr + q / 2) * MAP_SIZE + 2 * pc + q % 2];
                    if (v > best) begin
                        best = v;
                    end
                end
                expected.push_back(best);
            end
        end
    endfunction

    task automatic note_error();
        errors++;
        test_errs++;
    endtask

    ////////////////////////////////////////////////////////////
    // watching the DUT
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        pix_t exp_val;
        if (!rst) begin
            if (img_wr_en) begin
                img[img_wr_addr] = img_wr_data;
            end
            if (coef_wr_en && coef_wr_addr <= COEF_ADDR_W'(COEF_BIAS_IDX)) begin
                coef[coef_wr_addr] = coef_wr_data;
            end
            if (out_valid) begin
                if (!running) begin
                    $display("error: out_valid seen with no run in progress");
                    note_error();
                end else if (expected.size() == 0) begin
                    $display("error: test %s gave more results than expected", test_name);
                    note_error();
                end else begin
                    exp_val = expected.pop_front();
                    if (out_data !== exp_val) begin
                        $display("mismatch %s result %0d: expected %0d actual %0d",
                                 test_name, got, exp_val, out_data);
                        note_error();
                    end
                end
                got++;
            end
            if (done) begin
                if (!running) begin
                    $display("error: done pulsed with no run in progress");
                    note_error();
                end else begin
                    if (got != exp_results) begin
                        $display("error: test %s gave %0d results instead of %0d",
                                 test_name, got, exp_results);
                        note_error();
                    end
                    if (busy) begin
                        $display("error: busy still high at done in test %s", test_name);
                        note_error();
                    end
                    tests_run++;
                    if (test_errs == 0) begin
                        $display("test %s: ok, %0d results", test_name, got);
                    end else begin
                        tests_failed++;
                        $display("test %s: failed with %0d errors", test_name, test_errs);
                    end
                    running = 1'b0;
                end
            end
            // accepted start only, idle means neither busy nor done
            if (start && !busy && !done) begin
                build_expected();
                got       = 0;
                test_errs = 0;
                running   = 1'b1;
            end
        end
    end

endmodule

//--- verif/cnn_assert.sv
`timescale 1ns/10ps

module cnn_assert
    import cnn_ctrl_pkg::*;
#(
    parameter int IMG_SIZE = 8
) (
    input logic         clk,
    input logic         rst,
    input logic         start,
    input logic         busy,
    input logic         done,
    input logic         out_valid,
    input logic         img_wr_en,
    input logic         coef_wr_en,
    input layer_state_t state
);

    // at least one read per tap for every conv map pixel
    localparam int MIN_RUN = (IMG_SIZE - 2) * (IMG_SIZE - 2) * KER_TAPS;

    int run_cycles;         // cycles since the last accepted start
    int fail_count = 0;     // property failures so far

    always_ff @(posedge clk) begin
        if (rst) begin
            run_cycles <= 0;
        end else if (start && state == S_IDLE) begin
            run_cycles <= 0;
        end else begin
            run_cycles <= run_cycles + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // protocol properties
    ////////////////////////////////////////////////////////////

    done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            fail_count++;
            $error("done stayed high for more than one cycle");
        end

    valid_in_run: assert property (@(posedge clk) disable iff (rst) out_valid |-> busy)
        else begin
            fail_count++;
            $error("out_valid pulsed while busy was low");
        end

    no_load_busy: assert property (@(posedge clk) disable iff (rst)
        (img_wr_en || coef_wr_en) |-> !busy)
        else begin
            fail_count++;
            $error("image or coefficient write while busy");
        end

    run_not_short: assert property (@(posedge clk) disable iff (rst)
        done |-> run_cycles >= MIN_RUN)
        else begin
            fail_count++;
            $error("done arrived too soon after start");
        end

endmodule

//--- logic/cnn_top.sv
`timescale 1ns/10ps

module cnn_top
    import cnn_dim_pkg::*;
    import cnn_ctrl_pkg::*;
#(
    parameter  int IMG_SIZE = 8,
    localparam int IMG_AW   = $clog2(IMG_SIZE * IMG_SIZE),
    localparam int MAP_AW   = $clog2((IMG_SIZE - 2) * (IMG_SIZE - 2))
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   img_wr_en,
    input  logic [IMG_AW-1:0]      img_wr_addr,
    input  pix_t                   img_wr_data,
    input  logic                   coef_wr_en,
    input  logic [COEF_ADDR_W-1:0] coef_wr_addr,
    input  pix_t                   coef_wr_data,
    output logic                   busy,
    output logic                   done,
    output logic                   out_valid,
    output pix_t                   out_data
);

    localparam int IMG_DEPTH = IMG_SIZE * IMG_SIZE;
    localparam int MAP_DEPTH = (IMG_SIZE - 2) * (IMG_SIZE - 2);

    logic              conv_start;
    logic              pool_start;
    logic              conv_done;
    logic              pool_done;

    // image RAM read side, owned by conv
    logic              img_rd_en;
    logic [IMG_AW-1:0] img_rd_addr;
    pix_t              img_rd_data;

    // conv map, written by conv, read by pool
    logic              map_wr_en;
    logic [MAP_AW-1:0] map_wr_addr;
    pix_t              map_wr_data;
    logic              map_rd_en;
    logic [MAP_AW-1:0] map_rd_addr;
    pix_t              map_rd_data;

    ////////////////////////////////////////////////////////////
    // sequencing and layers
    ////////////////////////////////////////////////////////////

    layer_ctrl u_layer_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .conv_done  (conv_done),
        .pool_done  (pool_done),
        .conv_start (conv_start),
        .pool_start (pool_start),
        .busy       (busy),
        .done       (done)
    );

    conv_engine #(
        .IMG_SIZE (IMG_SIZE)
    ) u_conv_engine (
        .clk          (clk),
        .rst          (rst),
        .conv_start   (conv_start),
        .coef_wr_en   (coef_wr_en),
        .coef_wr_addr (coef_wr_addr),
        .coef_wr_data (coef_wr_data),
        .img_rd_en    (img_rd_en),
        .img_rd_addr  (img_rd_addr),
        .img_rd_data  (img_rd_data),
        .map_wr_en    (map_wr_en),
        .map_wr_addr  (map_wr_addr),
        .map_wr_data  (map_wr_data),
        .conv_done    (conv_done)
    );

    pool_engine #(
        .IMG_SIZE (IMG_SIZE)
    ) u_pool_engine (
        .clk         (clk),
        .rst         (rst),
        .pool_start  (pool_start),
        .map_rd_en   (map_rd_en),
        .map_rd_addr (map_rd_addr),
        .map_rd_data (map_rd_data),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .pool_done   (pool_done)
    );

    ////////////////////////////////////////////////////////////
    // feature memories
    ////////////////////////////////////////////////////////////

    feature_ram #(
        .DEPTH (IMG_DEPTH)
    ) img_ram (
        .clk     (clk),
        .wr_en   (img_wr_en),
        .wr_addr (img_wr_addr),
        .wr_data (img_wr_data),
        .rd_en   (img_rd_en),
        .rd_addr (img_rd_addr),
        .rd_data (img_rd_data)
    );

    feature_ram #(
        .DEPTH (MAP_DEPTH)
    ) map_ram (
        .clk     (clk),
        .wr_en   (map_wr_en),
        .wr_addr (map_wr_addr),
        .wr_data (map_wr_data),
        .rd_en   (map_rd_en),
        .rd_addr (map_rd_addr),
        .rd_data (map_rd_data)
    );

endmodule

//--- logic/pool_engine.sv
`timescale 1ns/10ps

module pool_engine
    import cnn_dim_pkg::*;
#(
    parameter  int IMG_SIZE = 8,
    localparam int MAP_AW   = $clog2((IMG_SIZE - 2) * (IMG_SIZE - 2))
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              pool_start,
    output logic              map_rd_en,
    output logic [MAP_AW-1:0] map_rd_addr,
    input  pix_t              map_rd_data,
    output logic              out_valid,
    output pix_t              out_data,
    output logic              pool_done
);

    localparam int MAP_SIZE  = IMG_SIZE - 2;
    localparam int POOL_SIZE = MAP_SIZE / 2;
    localparam int CNT_W     = $clog2(IMG_SIZE);

    ////////////////////////////////////////////////////////////
    // 2x2 window walk, four reads per window
    ////////////////////////////////////////////////////////////

    logic             active;
    logic [CNT_W-1:0] prow;
    logic [CNT_W-1:0] pcol;
    logic [1:0]       quad;     // {dy, dx} inside the window
    logic             last_quad;
    logic             last_pcol;
    logic             last_prow;

    assign last_quad = (quad == 2'd3);
    assign last_pcol = (pcol == CNT_W'(POOL_SIZE - 1));
    assign last_prow = (prow == CNT_W'(POOL_SIZE - 1));

    assign map_rd_en   = active;
    assign map_rd_addr = MAP_AW'((2 * prow + quad[1]) * MAP_SIZE + 2 * pcol + quad[0]);

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            prow   <= '0;
            pcol   <= '0;
            quad   <= '0;
        end else if (pool_start) begin
            active <= 1'b1;
            prow   <= '0;
            pcol   <= '0;
            quad   <= '0;
        end else if (active) begin
            quad <= quad + 1'b1;    // wraps to 0 after the fourth read
            if (last_quad) begin
                if (last_pcol) begin
                    pcol <= '0;
                    if (last_prow) begin
                        active <= 1'b0;
                    end else begin
                        prow <= prow + 1'b1;
                    end
                end else begin
                    pcol <= pcol + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // running max
    ////////////////////////////////////////////////////////////

    logic       rd_vld;
    logic [1:0] quad_d;
    logic       final_d;    // fourth read of the last window
    pix_t       run_max;
    pix_t       cand;

    // first datum seeds the max, signed compare after that
    always_comb begin
        if (quad_d == 2'd0 || map_rd_data > run_max) begin
            cand = map_rd_data;
        end else begin
            cand = run_max;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_vld    <= 1'b0;
            out_valid <= 1'b0;
            pool_done <= 1'b0;
        end else begin
            rd_vld    <= map_rd_en;
            out_valid <= rd_vld && (quad_d == 2'd3);
            pool_done <= rd_vld && (quad_d == 2'd3) && final_d;   // with last result
        end
    end

    always_ff @(posedge clk) begin
        quad_d  <= quad;
        final_d <= last_quad && last_pcol && last_prow;
        if (rd_vld) begin
            run_max <= cand;
        end
        if (rd_vld && quad_d == 2'd3) begin
            out_data <= cand;
        end
    end

endmodule

//--- logic/conv_engine.sv
`timescale 1ns/10ps

module conv_engine
    import cnn_dim_pkg::*;
    import cnn_ctrl_pkg::*;
#(
    parameter  int IMG_SIZE = 8,
    localparam int IMG_AW   = $clog2(IMG_SIZE * IMG_SIZE),
    localparam int MAP_AW   = $clog2((IMG_SIZE - 2) * (IMG_SIZE - 2))
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   conv_start,
    input  logic                   coef_wr_en,
    input  logic [COEF_ADDR_W-1:0] coef_wr_addr,
    input  pix_t                   coef_wr_data,
    output logic                   img_rd_en,
    output logic [IMG_AW-1:0]      img_rd_addr,
    input  pix_t                   img_rd_data,
    output logic                   map_wr_en,
    output logic [MAP_AW-1:0]      map_wr_addr,
    output pix_t                   map_wr_data,
    output logic                   conv_done
);

    localparam int KER_DIM   = 3;
    localparam int OUT_SIZE  = IMG_SIZE - 2;
    localparam int MAP_DEPTH = OUT_SIZE * OUT_SIZE;
    localparam int CNT_W     = $clog2(IMG_SIZE);

    ////////////////////////////////////////////////////////////
    // coefficient registers
    ////////////////////////////////////////////////////////////

    pix_t weight [KER_TAPS];
    pix_t bias;

    always_ff @(posedge clk) begin
        if (coef_wr_en) begin
            if (coef_wr_addr == COEF_ADDR_W'(COEF_BIAS_IDX)) begin
                bias <= coef_wr_data;
            end else if (coef_wr_addr < COEF_ADDR_W'(KER_TAPS)) begin
                weight[coef_wr_addr] <= coef_wr_data;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // window walk, one tap read per cycle
    ////////////////////////////////////////////////////////////

    logic                   active;
    logic [CNT_W-1:0]       row;
    logic [CNT_W-1:0]       col;
    logic [COEF_ADDR_W-1:0] tap;
    logic [CNT_W-1:0]       ky;
    logic [CNT_W-1:0]       kx;
    logic                   last_tap;
    logic                   last_col;
    logic                   last_row;

    // tap is row-major inside the 3x3 window
    assign ky = CNT_W'(tap / KER_DIM);
    assign kx = CNT_W'(tap % KER_DIM);

    assign last_tap = (tap == COEF_ADDR_W'(KER_TAPS - 1));
    assign last_col = (col == CNT_W'(OUT_SIZE - 1));
    assign last_row = (row == CNT_W'(OUT_SIZE - 1));

    assign img_rd_en   = active;
    assign img_rd_addr = IMG_AW'((row + ky) * IMG_SIZE + col + kx);

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            row    <= '0;
            col    <= '0;
            tap    <= '0;
        end else if (conv_start) begin
            active <= 1'b1;
            row    <= '0;
            col    <= '0;
            tap    <= '0;
        end else if (active) begin
            if (last_tap) begin
                tap <= '0;
                if (last_col) begin
                    col <= '0;
                    if (last_row) begin
                        active <= 1'b0;     // final pixel issued
                    end else begin
                        row <= row + 1'b1;
                    end
                end else begin
                    col <= col + 1'b1;
                end
            end else begin
                tap <= tap + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // MAC pipeline: read -> product -> accumulate -> write
    ////////////////////////////////////////////////////////////

    logic                        rd_vld;
    logic                        prod_vld;
    logic                        sum_vld;
    logic [COEF_ADDR_W-1:0]      tap_d1;
    logic [COEF_ADDR_W-1:0]      tap_d2;
    logic signed [2*PIX_W-1:0]   prod;
    acc_t                        acc;
    acc_t                        shifted;
    acc_t                        total;
    pix_t                        sat_val;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_vld      <= 1'b0;
            prod_vld    <= 1'b0;
            sum_vld     <= 1'b0;
            map_wr_en   <= 1'b0;
            map_wr_addr <= '0;
            conv_done   <= 1'b0;
        end else begin
            rd_vld    <= img_rd_en;             // matches RAM read latency
            prod_vld  <= rd_vld;
            sum_vld   <= prod_vld && (tap_d2 == COEF_ADDR_W'(KER_TAPS - 1));
            map_wr_en <= sum_vld;
            conv_done <= map_wr_en && (map_wr_addr == MAP_AW'(MAP_DEPTH - 1));
            if (conv_start) begin
                map_wr_addr <= '0;
            end else if (map_wr_en) begin
                map_wr_addr <= map_wr_addr + 1'b1;  // raster order of conv map
            end
        end
    end

    always_ff @(posedge clk) begin
        tap_d1 <= tap;
        tap_d2 <= tap_d1;
        prod   <= img_rd_data * weight[tap_d1];
        if (prod_vld) begin
            // tap 0 restarts the sum for a new pixel
            acc <= (tap_d2 == '0) ? acc_t'(prod) : acc + acc_t'(prod);
        end
        if (sum_vld) begin
            map_wr_data <= sat_val;
        end
    end

    // back to Q8.8 with floor, add bias, clamp
    always_comb begin
        shifted = acc >>> FRAC_W;
        total   = shifted + acc_t'(bias);
        if (total > acc_t'(PIX_MAX)) begin
            sat_val = PIX_MAX;
        end else if (total < acc_t'(PIX_MIN)) begin
            sat_val = PIX_MIN;
        end else begin
            sat_val = total[PIX_W-1:0];
        end
    end

endmodule

//--- logic/layer_ctrl.sv
`timescale 1ns/10ps

module layer_ctrl
    import cnn_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic conv_done,
    input  logic pool_done,
    output logic conv_start,
    output logic pool_start,
    output logic busy,
    output logic done
);

    layer_state_t state;

    ////////////////////////////////////////////////////////////
    // layer FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            conv_start <= 1'b0;
            pool_start <= 1'b0;
        end else begin
            conv_start <= 1'b0;     // start strobes last one cycle
            pool_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state      <= S_CONV;
                        conv_start <= 1'b1;
                    end
                end
                S_CONV: begin
                    if (conv_done) begin
                        state      <= S_POOL;
                        pool_start <= 1'b1;
                    end
                end
                S_POOL: begin
                    // pool_done comes with the last result
                    if (pool_done) begin
                        state <= S_DONE;
                    end
                end
                S_DONE: begin
                    state <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // start is ignored outside idle since busy covers conv and pool
    assign busy = (state == S_CONV) || (state == S_POOL);
    assign done = (state == S_DONE);    // single cycle, busy already low

endmodule

//--- logic/feature_ram.sv
`timescale 1ns/10ps

module feature_ram
    import cnn_dim_pkg::*;
#(
    parameter  int DEPTH = 64,
    localparam int AW    = $clog2(DEPTH)
) (
    input  logic          clk,
    input  logic          wr_en,
    input  logic [AW-1:0] wr_addr,
    input  pix_t          wr_data,
    input  logic          rd_en,
    input  logic [AW-1:0] rd_addr,
    output pix_t          rd_data
);

    pix_t mem [DEPTH];   // one feature map, raster order

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, data one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- logic/cnn_ctrl_pkg.sv
package cnn_ctrl_pkg;

    // layer sequencing
    typedef enum logic [1:0] {
        S_IDLE,
        S_CONV,
        S_POOL,
        S_DONE
    } layer_state_t;

    ////////////////////////////////////////////////////////////
    // coefficient space: 0..8 weights row-major, 9 bias
    ////////////////////////////////////////////////////////////

    localparam int KER_TAPS      = 9;
    localparam int COEF_BIAS_IDX = 9;
    localparam int COEF_ADDR_W   = 4;

endpackage

//--- logic/cnn_dim_pkg.sv
package cnn_dim_pkg;

    ////////////////////////////////////////////////////////////
    // data widths, Q8.8 fixed point
    ////////////////////////////////////////////////////////////

    localparam int PIX_W  = 16;    // pixel and coefficient width
    localparam int FRAC_W = 8;     // fractional bits
    localparam int ACC_W  = 36;    // nine 32b products plus growth

    typedef logic signed [PIX_W-1:0] pix_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    // saturation bounds of a pixel
    localparam pix_t PIX_MAX = {1'b0, {(PIX_W-1){1'b1}}};
    localparam pix_t PIX_MIN = {1'b1, {(PIX_W-1){1'b0}}};

endpackage
